/* run.sh */
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -Mdir obj_dir -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

grep -q "Done: no errors" sim.log

/* source/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu import rv32i_pkg::*; (
  input  alu_ops_t       aluop,
  input  rv32i_word      a,
  input  rv32i_word      b,
  output rv32i_word      f,
  input  branch_funct3_t cmpop,
  input  rv32i_word      cmp_a,
  input  rv32i_word      cmp_b,
  output logic           br_en
);

  // --------------------------------------------------------------------------
  // Arithmetic and logic
  // --------------------------------------------------------------------------
  always_comb begin
    case (aluop)
      alu_add:  f = a + b;
      alu_sub:  f = a - b;
      alu_sll:  f = a << b[4:0];
      alu_slt:  f = {31'd0, $signed(a) < $signed(b)};
      alu_sltu: f = {31'd0, a < b};
      alu_xor:  f = a ^ b;
      alu_srl:  f = a >> b[4:0];
      alu_sra:  f = $signed(a) >>> b[4:0];
      alu_or:   f = a | b;
      alu_and:  f = a & b;
      default:  f = b;  // Pass-through for LUI.
    endcase
  end

  // --------------------------------------------------------------------------
  // Branch comparator
  // --------------------------------------------------------------------------
  always_comb begin
    case (cmpop)
      beq:     br_en = (cmp_a == cmp_b);
      bne:     br_en = (cmp_a != cmp_b);
      blt:     br_en = ($signed(cmp_a) < $signed(cmp_b));
      bge:     br_en = ($signed(cmp_a) >= $signed(cmp_b));
      bltu:    br_en = (cmp_a < cmp_b);
      bgeu:    br_en = (cmp_a >= cmp_b);
      default: br_en = 1'b0;
    endcase
  end

endmodule

/* source/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode import rv32i_pkg::*; (
  input  rv32i_word   instruction,
  input  rv32i_word   pc,
  input  rv32i_word   rs1_data,
  input  rv32i_word   rs2_data,
  output rv32i_ctrl_t ctrl,
  output rv32i_word   alu_a,
  output rv32i_word   alu_b,
  output rv32i_word   cmp_b
);

  rv32i_opcode_t opcode;
  logic [2:0]    funct3;
  rv32i_word     imm_i, imm_s, imm_b, imm_u, imm_j;

  // ALU operation for register and immediate arithmetic.
  function automatic alu_ops_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode = rv32i_opcode_t'(instruction[6:0]);
  assign funct3 = instruction[14:12];

  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};
  assign imm_u = {instruction[31:12], 12'h000};
  assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};

  always_comb begin
    // No-operation unless the opcode is recognised.
    ctrl.opcode    = op_imm;
    ctrl.aluop     = alu_add;
    ctrl.cmpop     = beq;
    ctrl.funct3    = funct3;
    ctrl.pcmux_sel = pc_plus4;
    ctrl.cmp_imm   = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.rd        = 5'd0;
    alu_a          = rs1_data;
    alu_b          = imm_i;

    case (opcode)
      op_lui: begin
        ctrl.opcode = op_lui;
        ctrl.aluop  = alu_pass_b;
        ctrl.rd     = instruction[11:7];
        alu_b       = imm_u;
      end
      op_auipc: begin
        ctrl.opcode = op_auipc;
        ctrl.rd     = instruction[11:7];
        alu_a       = pc;
        alu_b       = imm_u;
      end
      op_jal: begin
        ctrl.opcode    = op_jal;
        ctrl.pcmux_sel = alu_out;
        ctrl.rd        = instruction[11:7];
        alu_a          = pc;
        alu_b          = imm_j;
      end
      op_jalr: begin
        ctrl.opcode    = op_jalr;
        ctrl.pcmux_sel = alu_mod2;
        ctrl.rd        = instruction[11:7];
      end
      op_br: begin
        ctrl.opcode    = op_br;
        ctrl.cmpop     = branch_funct3_t'(funct3);
        ctrl.pcmux_sel = alu_out;
        alu_a          = pc;
        alu_b          = imm_b;
      end
      op_load: begin
        ctrl.opcode   = op_load;
        ctrl.mem_read = 1'b1;
        ctrl.rd       = instruction[11:7];
      end
      op_store: begin
        ctrl.opcode    = op_store;
        ctrl.mem_write = 1'b1;
        alu_b          = imm_s;
      end
      op_imm: begin
        ctrl.aluop   = arith_op(funct3, (funct3 == 3'b101) && instruction[30]);
        ctrl.cmp_imm = 1'b1;
        ctrl.rd      = instruction[11:7];
      end
      op_reg: begin
        ctrl.opcode = op_reg;
        ctrl.aluop  = arith_op(funct3, instruction[30]);
        ctrl.rd     = instruction[11:7];
        alu_b       = rs2_data;
      end
      default: ;  // FENCE, SYSTEM and unknown codes.
    endcase
  end

  assign cmp_b = ctrl.cmp_imm ? imm_i : rs2_data;

endmodule

/* source/ex_mem_if.sv */
`timescale 1ns/1ps

interface ex_mem_if import rv32i_pkg::*; ();

  // Entry written by the execute stage.
  logic        push;
  rv32i_ctrl_t ctrl;
  rv32i_word   addr;
  logic [3:0]  byte_enable;
  rv32i_word   wdata;
  logic        pop_credit;

  // Head of the queue.
  logic        deq_valid;
  logic        deq_ready;
  rv32i_ctrl_t head_ctrl;
  rv32i_word   head_addr;
  logic [3:0]  head_byte_enable;
  rv32i_word   head_wdata;

  modport producer (
    output push, ctrl, addr, byte_enable, wdata,
    input  pop_credit
  );

  modport buffer (
    input  push, ctrl, addr, byte_enable, wdata, deq_ready,
    output pop_credit, deq_valid, head_ctrl, head_addr, head_byte_enable, head_wdata
  );

  modport consumer (
    input  deq_valid, head_ctrl, head_addr, head_byte_enable, head_wdata,
    output deq_ready
  );

endinterface

/* source/ex_mem_queue.sv */
`timescale 1ns/1ps

module ex_mem_queue import rv32i_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst,
  ex_mem_if.buffer mem
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  rv32i_ctrl_t   ctrl_q [FIFO_DEPTH];
  rv32i_word     addr_q [FIFO_DEPTH];
  logic [3:0]    be_q   [FIFO_DEPTH];
  rv32i_word     data_q [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic          pop;

  // Wraps at FIFO_DEPTH, which need not be a power of two.
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    next_ptr = (p == PW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign mem.deq_valid        = (count != '0);
  assign pop                  = mem.deq_valid && mem.deq_ready;
  assign mem.head_ctrl        = ctrl_q[rd_ptr];
  assign mem.head_addr        = addr_q[rd_ptr];
  assign mem.head_byte_enable = be_q[rd_ptr];
  assign mem.head_wdata       = data_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (mem.push) begin
      ctrl_q[wr_ptr] <= mem.ctrl;
      addr_q[wr_ptr] <= mem.addr;
      be_q[wr_ptr]   <= mem.byte_enable;
      data_q[wr_ptr] <= mem.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      mem.pop_credit <= 1'b0;
    end else begin
      if (mem.push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count          <= count + CW'(mem.push) - CW'(pop);
      mem.pop_credit <= pop;  // One credit back per pop.
    end
  end

endmodule

/* source/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import rv32i_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          valid,
  input  rv32i_ctrl_t   ctrl,
  input  rv32i_word     alu_a,
  input  rv32i_word     alu_b,
  input  rv32i_word     cmp_a,
  input  rv32i_word     cmp_b,
  input  rv32i_word     rs2_data,
  output logic          ready,
  output logic          br_taken,
  output pcmux_sel_t    pcmux_sel,
  output rv32i_word     alu_out_to_pc,
  ex_mem_if.producer    mem
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  rv32i_word      alu_f;
  logic           br_en;
  logic           is_mem;
  logic           is_jump;
  logic [3:0]     be_base;
  logic [CW-1:0]  credits;

  ex_alu u_alu (
    .aluop (ctrl.aluop),
    .a     (alu_a),
    .b     (alu_b),
    .f     (alu_f),
    .cmpop (ctrl.cmpop),
    .cmp_a (cmp_a),
    .cmp_b (cmp_b),
    .br_en (br_en)
  );

  // --------------------------------------------------------------------------
  // Branch resolution
  // --------------------------------------------------------------------------
  assign is_jump  = (ctrl.opcode == op_jal) || (ctrl.opcode == op_jalr);
  assign br_taken = valid && (is_jump || (br_en && ctrl.opcode == op_br));
  assign pcmux_sel = br_taken ? ctrl.pcmux_sel : pc_plus4;

  always_comb begin
    if (!valid)
      alu_out_to_pc = '0;
    else if (ctrl.opcode == op_jalr)
      alu_out_to_pc = {alu_f[31:1], 1'b0};  // JALR clears the low bit.
    else
      alu_out_to_pc = alu_f;
  end

  // --------------------------------------------------------------------------
  // Byte enables, shifted by the address offset
  // --------------------------------------------------------------------------
  always_comb begin
    case (load_funct3_t'(ctrl.funct3))
      lb, lbu: be_base = 4'b0001;
      lh, lhu: be_base = 4'b0011;
      default: be_base = 4'b1111;
    endcase
  end

  assign is_mem = ctrl.mem_read || ctrl.mem_write;

  // Credits track free queue slots.
  assign ready = (credits != '0);

  always_ff @(posedge clk) begin
    if (rst)
      credits <= CW'(FIFO_DEPTH);
    else
      credits <= credits - CW'(mem.push) + CW'(mem.pop_credit);
  end

  assign mem.push        = valid && is_mem && ready;
  assign mem.ctrl        = ctrl;
  assign mem.addr        = alu_f;
  assign mem.byte_enable = is_mem ? (be_base << alu_f[1:0]) : 4'b0000;
  assign mem.wdata       = rs2_data;

endmodule

/* source/ex_subsystem.sv */
`timescale 1ns/1ps

module ex_subsystem import rv32i_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  rv32i_word  in_pc,
  input  rv32i_word  in_instruction,
  input  rv32i_word  in_rs1_data,
  input  rv32i_word  in_rs2_data,
  output logic       in_ready,
  output logic       br_taken,
  output pcmux_sel_t pcmux_sel,
  output rv32i_word  alu_out_to_pc,
  input  logic       mem_ready,
  output logic       mem_valid,
  output rv32i_word  mem_addr,
  output logic       mem_read,
  output logic       mem_write,
  output logic [3:0] mem_byte_enable,
  output rv32i_word  mem_wdata
);

  rv32i_ctrl_t ctrl;
  rv32i_word   alu_a, alu_b, cmp_b;

  ex_mem_if ex_mem ();

  ex_decode u_decode (
    .instruction (in_instruction),
    .pc          (in_pc),
    .rs1_data    (in_rs1_data),
    .rs2_data    (in_rs2_data),
    .ctrl        (ctrl),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .cmp_b       (cmp_b)
  );

  ex_stage #(.FIFO_DEPTH(FIFO_DEPTH)) u_ex (
    .clk           (clk),
    .rst           (rst),
    .valid         (in_valid),
    .ctrl          (ctrl),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .cmp_a         (in_rs1_data),
    .cmp_b         (cmp_b),
    .rs2_data      (in_rs2_data),
    .ready         (in_ready),
    .br_taken      (br_taken),
    .pcmux_sel     (pcmux_sel),
    .alu_out_to_pc (alu_out_to_pc),
    .mem           (ex_mem.producer)
  );

  ex_mem_queue #(.FIFO_DEPTH(FIFO_DEPTH)) u_queue (
    .clk (clk),
    .rst (rst),
    .mem (ex_mem.buffer)
  );

  mem_access u_mem (
    .clk             (clk),
    .rst             (rst),
    .mem             (ex_mem.consumer),
    .mem_ready       (mem_ready),
    .mem_valid       (mem_valid),
    .mem_addr        (mem_addr),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_byte_enable (mem_byte_enable),
    .mem_wdata       (mem_wdata)
  );

endmodule

/* source/mem_access.sv */
`timescale 1ns/1ps

module mem_access import rv32i_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  ex_mem_if.consumer mem,
  input  logic       mem_ready,
  output logic       mem_valid,
  output rv32i_word  mem_addr,
  output logic       mem_read,
  output logic       mem_write,
  output logic [3:0] mem_byte_enable,
  output rv32i_word  mem_wdata
);

  // Take a new head when idle or when the current request completes.
  assign mem.deq_ready = !mem_valid || mem_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid       <= 1'b0;
      mem_read        <= 1'b0;
      mem_write       <= 1'b0;
      mem_byte_enable <= 4'b0000;
    end else if (mem.deq_ready) begin
      mem_valid       <= mem.deq_valid;
      mem_read        <= mem.deq_valid && mem.head_ctrl.mem_read;
      mem_write       <= mem.deq_valid && mem.head_ctrl.mem_write;
      mem_byte_enable <= mem.deq_valid ? mem.head_byte_enable : 4'b0000;
    end
  end

  // Address and store data.
  always_ff @(posedge clk) begin
    if (mem.deq_ready && mem.deq_valid) begin
      mem_addr <= {mem.head_addr[31:2], 2'b00};
      if (mem.head_ctrl.mem_write)
        mem_wdata <= mem.head_wdata << {mem.head_addr[1:0], 3'b000};
      else
        mem_wdata <= '0;
    end
  end

endmodule

/* source/rv32i_pkg.sv */
package rv32i_pkg;

  typedef logic [31:0] rv32i_word;

  // Base opcodes of RV32I.
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_ops_t;

  // Values follow funct3 of the branch instructions.
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // Stores reuse lb/lh/lw for sb/sh/sw.
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [1:0] {
    pc_plus4,
    alu_out,
    alu_mod2
  } pcmux_sel_t;

  typedef struct packed {
    rv32i_opcode_t  opcode;
    alu_ops_t       aluop;
    branch_funct3_t cmpop;
    logic [2:0]     funct3;
    pcmux_sel_t     pcmux_sel;
    logic           cmp_imm;   // Compare against the I immediate.
    logic           mem_read;
    logic           mem_write;
    logic [4:0]     rd;
  } rv32i_ctrl_t;

endpackage

/* tb.f */
source/rv32i_pkg.sv
source/ex_mem_if.sv
source/ex_decode.sv
source/ex_alu.sv
source/ex_stage.sv
source/ex_mem_queue.sv
source/mem_access.sv
source/ex_subsystem.sv
tests/ex_checker.sv
tests/tb_top.sv

/* tests/ex_checker.sv */
`timescale 1ns/1ps

module ex_checker import rv32i_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input logic       clk,
  input logic       rst,
  input logic       in_valid,
  input rv32i_word  in_pc,
  input rv32i_word  in_instruction,
  input rv32i_word  in_rs1_data,
  input rv32i_word  in_rs2_data,
  input logic       in_ready,
  input logic       br_taken,
  input pcmux_sel_t pcmux_sel,
  input rv32i_word  alu_out_to_pc,
  input logic       mem_ready,
  input logic       mem_valid,
  input rv32i_word  mem_addr,
  input logic       mem_read,
  input logic       mem_write,
  input logic [3:0] mem_byte_enable,
  input rv32i_word  mem_wdata
);

  int errors = 0;
  int tests = 0;
  int passed = 0;
  int low_accepts = 0;  // Non-memory accepts while in_ready is low.
  int accept_id = 0;
  int pushed = 0;
  int completed = 0;
  logic rst_d = 1'b1;

  // Expected memory requests, oldest first.
  rv32i_word  q_addr [$];
  rv32i_word  q_wdata [$];
  logic [3:0] q_be [$];
  logic       q_write [$];
  int         q_id [$];
  int         q_bad [$];

  logic [6:0] op;
  logic [2:0] f3;
  rv32i_word  imm_i, imm_s, imm_b, imm_j, ea, target;
  logic       taken, is_mem;
  logic [1:0] sel;
  logic [3:0] be_base, be_exp;
  int         bad, id;

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act, inout int cnt);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input int num, input int cnt);
    tests++;
    errors += cnt;
    if (cnt == 0) begin
      passed++;
      $display("test %0d ok", num);
    end else begin
      $display("test %0d failed with %0d errors", num, cnt);
    end
  endtask

  // --------------------------------------------------------------------------
  // Reset state, accept cycle and memory completion, sampled mid-cycle
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    rst_d <= rst;
    if (rst_d && !rst) begin
      bad = 0;
      compare_value("in_ready", 1, in_ready, bad);
      compare_value("mem_valid", 0, mem_valid, bad);
      compare_value("mem_read", 0, mem_read, bad);
      compare_value("mem_write", 0, mem_write, bad);
      compare_value("mem_byte_enable", 0, mem_byte_enable, bad);
      finish_test(-1, bad);  // Reset test.
    end

    if (!rst && in_valid) begin
      op     = in_instruction[6:0];
      f3     = in_instruction[14:12];
      imm_i  = {{20{in_instruction[31]}}, in_instruction[31:20]};
      imm_s  = {{20{in_instruction[31]}}, in_instruction[31:25], in_instruction[11:7]};
      imm_b  = {{19{in_instruction[31]}}, in_instruction[31], in_instruction[7],
                in_instruction[30:25], in_instruction[11:8], 1'b0};
      imm_j  = {{11{in_instruction[31]}}, in_instruction[31], in_instruction[19:12],
                in_instruction[20], in_instruction[30:21], 1'b0};
      is_mem = (op == 7'b0000011) || (op == 7'b0100011);
      if (!is_mem || in_ready) begin
        accept_id++;
        bad = 0;
        taken = 1'b0;
        sel = 2'd0;  // pc + 4.
        if (op == 7'b1100011) begin
          case (f3)
            3'b000:  taken = in_rs1_data == in_rs2_data;
            3'b001:  taken = in_rs1_data != in_rs2_data;
            3'b100:  taken = $signed(in_rs1_data) < $signed(in_rs2_data);
            3'b101:  taken = $signed(in_rs1_data) >= $signed(in_rs2_data);
            3'b110:  taken = in_rs1_data < in_rs2_data;
            3'b111:  taken = in_rs1_data >= in_rs2_data;
            default: taken = 1'b0;
          endcase
          sel = taken ? 2'd1 : 2'd0;
          target = in_pc + imm_b;
          compare_value("alu_out_to_pc", target, alu_out_to_pc, bad);
        end else if (op == 7'b1101111) begin
          taken = 1'b1;
          sel = 2'd1;
          target = in_pc + imm_j;
          compare_value("alu_out_to_pc", target, alu_out_to_pc, bad);
        end else if (op == 7'b1100111) begin
          taken = 1'b1;
          sel = 2'd2;
          target = (in_rs1_data + imm_i) & ~32'd1;
          compare_value("alu_out_to_pc", target, alu_out_to_pc, bad);
        end
        compare_value("br_taken", taken, br_taken, bad);
        compare_value("pcmux_sel", sel, pcmux_sel, bad);

        if (is_mem) begin
          ea = in_rs1_data + ((op == 7'b0100011) ? imm_s : imm_i);
          case (f3[1:0])
            2'b00:   be_base = 4'b0001;
            2'b01:   be_base = 4'b0011;
            default: be_base = 4'b1111;
          endcase
          be_exp = be_base << ea[1:0];
          q_addr.push_back({ea[31:2], 2'b00});
          q_wdata.push_back(in_rs2_data << (8 * ea[1:0]));
          q_be.push_back(be_exp);
          q_write.push_back(op == 7'b0100011);
          q_id.push_back(accept_id);
          q_bad.push_back(bad);  // Memory tests finish at completion.
          pushed++;
          if (pushed - completed > FIFO_DEPTH + 1)
            report_failure("more memory instructions accepted than the buffer can hold");
        end else begin
          if (!in_ready) low_accepts++;
          finish_test(accept_id, bad);
        end
      end
    end

    if (!rst && mem_valid && mem_ready) begin
      if (q_addr.size() == 0) begin
        report_failure("memory request with no instruction behind it");
      end else begin
        bad = q_bad.pop_front();
        id = q_id.pop_front();
        compare_value("mem_addr", q_addr.pop_front(), mem_addr, bad);
        compare_value("mem_byte_enable", q_be.pop_front(), mem_byte_enable, bad);
        compare_value("mem_write", q_write[0], mem_write, bad);
        compare_value("mem_read", !q_write[0], mem_read, bad);
        if (q_write[0])
          compare_value("mem_wdata", q_wdata[0], mem_wdata, bad);
        void'(q_write.pop_front());
        void'(q_wdata.pop_front());
        completed++;
        finish_test(id, bad);
      end
    end
  end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
  import rv32i_pkg::*;

  localparam int DEPTH = 4;
  localparam int MAX_TESTS = 96;

  logic       clk = 1'b0;
  logic       rst;
  logic       in_valid, in_ready, br_taken, mem_ready, mem_valid, mem_read, mem_write;
  rv32i_word  in_pc, in_instruction, in_rs1_data, in_rs2_data, alu_out_to_pc;
  rv32i_word  mem_addr, mem_wdata;
  pcmux_sel_t pcmux_sel;
  logic [3:0] mem_byte_enable;

  // Stimulus table; phase selects the memory ready model.
  rv32i_word tbl_instr [MAX_TESTS];
  rv32i_word tbl_pc [MAX_TESTS];
  rv32i_word tbl_rs1 [MAX_TESTS];
  rv32i_word tbl_rs2 [MAX_TESTS];
  int        tbl_phase [MAX_TESTS];
  int        n = 0;
  int        phase = 0;
  int        hold = 0;
  int        cycles = 0;
  int        limit = 100;

  always #2 clk = ~clk;

  ex_subsystem #(.FIFO_DEPTH(DEPTH)) UUT (.*);
  ex_checker #(.FIFO_DEPTH(DEPTH)) u_check (.*);

  function automatic rv32i_word enc_i(input logic [6:0] op, input logic [2:0] f3,
                                      input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, op};
  endfunction

  function automatic rv32i_word enc_s(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv32i_word enc_b(input logic [2:0] f3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd3, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv32i_word enc_j(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
  endfunction

  task automatic add_test(input rv32i_word instr, input rv32i_word pc, input rv32i_word rs1,
                          input rv32i_word rs2, input int ph);
    tbl_instr[n] = instr;
    tbl_pc[n]    = pc;
    tbl_rs1[n]   = rs1;
    tbl_rs2[n]   = rs2;
    tbl_phase[n] = ph;
    n++;
  endtask

  task automatic build_table();
    logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [2:0] ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    for (int f = 0; f < 6; f++) begin
      add_test(enc_b(br_f3[f], 13'd16), 32'h400 + 16 * f, 32'd5, 32'd5, 0);
      add_test(enc_b(br_f3[f], 13'h1ff8), 32'h404 + 16 * f, 32'hffff_fffd, 32'd2, 0);
      add_test(enc_b(br_f3[f], 13'd64), 32'h408 + 16 * f, 32'hf000_0000, 32'd1, 0);
    end
    add_test(enc_j(21'h100), 32'h800, 0, 0, 0);
    add_test(enc_j(21'h1ffff0), 32'h900, 0, 0, 0);
    add_test(enc_i(7'b1100111, 3'd0, 12'd4), 32'ha00, 32'h1003, 0, 0);
    for (int f = 0; f < 5; f++)
      for (int off = 0; off < 4; off++)
        add_test(enc_i(7'b0000011, ld_f3[f], 12'h10), 0, 32'h2000 + off, 0, 0);
    for (int f = 0; f < 3; f++)
      for (int off = 0; off < 4; off++)
        add_test(enc_s(f[2:0], 12'h20), 0, 32'h3000 + off, 32'ha1b2_c3d4, 1);
    // Fill the buffer and the memory port, then arithmetic while in_ready is low.
    for (int k = 0; k < DEPTH + 1; k++)
      add_test(enc_i(7'b0000011, 3'd2, 12'd0), 0, 32'h4000 + 4 * k, 0, 2);
    for (int k = 0; k < 3; k++)
      add_test(enc_i(7'b0010011, 3'd0, 12'd7), 0, k, 0, 2);
    add_test(enc_s(3'd0, 12'd1), 0, 32'h5000, 32'h0000_0055, 2);
    add_test(enc_i(7'b0000011, 3'd4, 12'd3), 0, 32'h5000, 0, 2);
  endtask

  // Memory ready model. Phase is sampled at the edge, ready driven just after it.
  initial begin
    logic next_ready;
    void'($urandom(35));
    mem_ready = 1'b1;
    forever begin
      @(posedge clk);
      if (phase == 2 && hold < 40) begin
        next_ready = 1'b0;
        hold++;
      end else if (phase == 1) begin
        next_ready = 1'($urandom % 2);
      end else begin
        next_ready = 1'b1;
      end
      #1 mem_ready = next_ready;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles with %0d memory requests outstanding", limit,
               u_check.q_addr.size());
      $display("tests %0d passed %0d errors %0d", u_check.tests, u_check.passed,
               u_check.errors);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    logic accepted;
    rst = 1'b1;
    in_valid = 1'b0;
    in_pc = '0;
    in_instruction = 32'h0000_0013;
    in_rs1_data = '0;
    in_rs2_data = '0;
    build_table();
    limit = 20 * n + 100;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;

    for (int i = 0; i < n; i++) begin
      // Back-pressure starts from an empty buffer and an idle memory port.
      if (tbl_phase[i] == 2 && phase != 2) begin
        in_valid = 1'b0;
        phase = 0;
        while (u_check.q_addr.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
      end
      phase = tbl_phase[i];
      in_valid = 1'b1;
      in_instruction = tbl_instr[i];
      in_pc = tbl_pc[i];
      in_rs1_data = tbl_rs1[i];
      in_rs2_data = tbl_rs2[i];
      do begin
        @(negedge clk);
        accepted = in_ready || !(tbl_instr[i][6:0] inside {7'b0000011, 7'b0100011});
        @(posedge clk);
        #1;
      end while (!accepted);
    end
    in_valid = 1'b0;
    phase = 0;

    while (u_check.q_addr.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);
    if (u_check.low_accepts == 0)
      u_check.report_failure("in_ready never fell while memory was stalled");

    $display("tests %0d passed %0d errors %0d", u_check.tests, u_check.passed,
             u_check.errors);
    if (u_check.errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
